// File: Makefile
TOP := tb_cpu_front
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Entry steps of one bus cycle each
localparam int st_idle = 0;
localparam int st_dummy0 = 1;
localparam int st_push_pch = 3;
localparam int st_push_p = 5;
localparam int st_vec_lo = 6;
localparam int st_vec_hi = 7;

// Interrupt sources
localparam int k_none = 0;
localparam int k_res = 1;
localparam int k_nmi = 2;
localparam int k_irq = 3;

// Registered state as the DUT holds it between edges
logic m_nmi_s, m_irq_s, m_res_s, m_rdy_s;
// SO chain, newest sample in bit 0
logic [2:0] m_so;
logic m_so_set, m_nmi_prev, m_nmi_lat, m_res_req, m_pc_load;
int m_state, m_kind_q;
logic [7:0] m_sp, m_vec_lo;
logic [15:0] m_pc_new;

// Values of the current cycle
int m_kind, m_step;
logic m_start, m_push, m_adv, m_vdone, s_rnw, e_busy, e_rnw, e_sync;
logic [15:0] m_vec, s_addr, e_addr;
logic [7:0] s_data, e_data;

task automatic clear_model();
	m_nmi_s = 1'b0;
	m_irq_s = 1'b0;
	// Reset pin seen as held
	m_res_s = 1'b1;
	m_rdy_s = 1'b1;
	m_so = 3'b000;
	m_so_set = 1'b0;
	m_nmi_prev = 1'b0;
	m_nmi_lat = 1'b0;
	// Power-up asks for the reset entry
	m_res_req = 1'b1;
	m_pc_load = 1'b0;
	m_state = st_idle;
	m_kind_q = k_none;
	m_sp = 8'h00;
endtask

// Bus cycle expected from the current inputs
task automatic predict_bus();
	// Reset, then NMI, then unmasked IRQ
	if (m_res_s)
		m_kind = k_none;
	else if (m_res_req)
		m_kind = k_res;
	else if (m_nmi_lat)
		m_kind = k_nmi;
	else if (m_irq_s && !p_flags[2])
		m_kind = k_irq;
	else
		m_kind = k_none;
	m_start = (m_state == st_idle) && (m_kind != k_none) && (core_fetch || m_kind == k_res);
	m_step = m_start ? st_dummy0 : m_state;
	e_busy = (m_step != st_idle);
	m_push = (m_step >= st_push_pch) && (m_step <= st_push_p);
	m_vec = (m_kind_q == k_res) ? 16'hfffc : ((m_kind_q == k_nmi) ? 16'hfffa : 16'hfffe);
	s_addr = pc;
	s_data = 8'h00;
	s_rnw = 1'b1;
	case (m_step)
		st_dummy0: s_addr = core_addr;
		st_push_pch: s_data = pc[15:8];
		st_push_pch + 1: s_data = pc[7:0];
		st_push_p: s_data = p_flags & 8'hef;
		st_vec_lo: s_addr = m_vec;
		st_vec_hi: s_addr = m_vec + 16'd1;
		default: s_addr = pc;
	endcase
	// Stack slots are read only for reset
	if (m_push) begin
		s_addr = {8'h01, m_sp};
		s_rnw = (m_kind_q == k_res);
	end
	m_adv = !s_rnw || m_rdy_s;
	m_vdone = (m_step == st_vec_hi) && m_adv;
	e_addr = e_busy ? s_addr : core_addr;
	e_data = e_busy ? s_data : core_data;
	e_rnw = e_busy ? s_rnw : core_rnw;
	e_sync = core_fetch && !e_busy;
endtask

// Register update at the coming rising edge
task automatic update_model();
	if (m_nmi_s && !m_nmi_prev)
		m_nmi_lat = 1'b1;
	else if (m_vdone && m_kind_q == k_nmi)
		m_nmi_lat = 1'b0;
	m_nmi_prev = m_nmi_s;
	if (m_res_s)
		m_res_req = 1'b1;
	else if (m_start && m_kind == k_res)
		m_res_req = 1'b0;
	if (m_start)
		m_kind_q = m_kind;
	if (m_adv && m_push)
		m_sp = m_sp - 8'd1;
	if (m_step == st_vec_lo && m_adv)
		m_vec_lo = data_in;
	if (m_vdone)
		m_pc_new = {data_in, m_vec_lo};
	m_pc_load = m_vdone;
	if (m_step == st_idle || m_vdone)
		m_state = st_idle;
	else if (m_adv)
		m_state = m_step + 1;
	else
		m_state = m_step;
	// Pulse from the delayed pair
	m_so_set = m_so[2] & ~m_so[1];
	m_so = {m_so[1:0], so};
	m_nmi_s = !n_nmi;
	m_irq_s = !n_irq;
	m_res_s = !n_res;
	m_rdy_s = rdy;
endtask

`endif

// File: sim/tb_cpu_front.sv
`timescale 1ns/1ps

module tb_cpu_front;

	localparam int reset_cycles = 4;
	localparam int run_cycles = 3000;
	// A third of slack on top of the run
	localparam int timeout_cycles = run_cycles * 4 / 3;

	logic phi0, rst_n, n_nmi, n_irq, n_res, rdy, so;
	logic [15:0] core_addr, pc;
	logic [7:0] core_data, p_flags, data_in;
	logic core_rnw, core_fetch;
	logic [15:0] addr, pc_new;
	logic [7:0] data_out;
	logic rnw, sync, pc_load, i_set, so_set, busy;

	integer seed;
	int cycle;
	int tick = 0;
	// Seen sequences and stalls
	int n_res_seq, n_nmi_seq, n_irq_seq, n_rstall, n_wstall, n_so;

	`include "tb_model.svh"

	cpu_front dut (
		.phi0(phi0), .rst_n(rst_n), .n_nmi(n_nmi), .n_irq(n_irq), .n_res(n_res),
		.rdy(rdy), .so(so), .core_addr(core_addr), .core_data(core_data),
		.core_rnw(core_rnw), .core_fetch(core_fetch), .pc(pc), .p_flags(p_flags),
		.data_in(data_in), .addr(addr), .data_out(data_out), .rnw(rnw), .sync(sync),
		.pc_new(pc_new), .pc_load(pc_load), .i_set(i_set), .so_set(so_set), .busy(busy)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
			fail_run($sformatf("MISMATCH %s got %h expected %h at cycle %0d",
				name, got, exp, cycle));
	endtask

	// New random inputs for one cycle
	task drive_inputs();
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] rc;
		ra = $random(seed);
		rb = $random(seed);
		rc = $random(seed);
		core_addr <= ra[15:0];
		pc <= ra[31:16];
		core_data <= rb[7:0];
		p_flags <= rb[15:8];
		data_in <= rb[23:16];
		core_rnw <= rb[24];
		// Low about one cycle in four
		rdy <= (rb[26:25] != 2'b00);
		core_fetch <= (cycle % 3 == 0);
		// Sparse pin toggles
		if (rc[5:0] == 6'd0)
			n_nmi <= ~n_nmi;
		if (rc[10:6] == 5'd0)
			n_irq <= ~n_irq;
		if (rc[14:11] == 4'd0)
			so <= ~so;
		// Rare reset pulses of a few cycles
		if (n_res) begin
			if (rc[24:15] == 10'd0)
				n_res <= 1'b0;
		end else if (rc[27:25] == 3'd0) begin
			n_res <= 1'b1;
		end
	endtask

	initial begin
		phi0 = 1'b0;
		forever #4 phi0 = ~phi0;
	end

	// Compare at the falling edge when inputs have settled
	always @(negedge phi0) begin
		if (rst_n !== 1'b1) begin
			clear_model();
		end else begin
			predict_bus();
			check_value("addr", addr, e_addr);
			check_value("data_out", 16'(data_out), 16'(e_data));
			check_value("rnw", 16'(rnw), 16'(e_rnw));
			check_value("sync", 16'(sync), 16'(e_sync));
			check_value("busy", 16'(busy), 16'(e_busy));
			check_value("so_set", 16'(so_set), 16'(m_so_set));
			check_value("pc_load", 16'(pc_load), 16'(m_pc_load));
			check_value("i_set", 16'(i_set), 16'(m_pc_load));
			if (m_pc_load)
				check_value("pc_new", pc_new, m_pc_new);
			if (m_start && m_kind == k_res)
				n_res_seq++;
			if (m_start && m_kind == k_nmi)
				n_nmi_seq++;
			if (m_start && m_kind == k_irq)
				n_irq_seq++;
			if (e_busy && !m_rdy_s && s_rnw)
				n_rstall++;
			if (e_busy && !m_rdy_s && !s_rnw)
				n_wstall++;
			if (m_so_set)
				n_so++;
			update_model();
		end
	end

	always @(posedge phi0) begin
		tick++;
		if (tick >= timeout_cycles)
			fail_run("Timeout, the run did not end within the cycle limit");
	end

	initial begin
		seed = 32'h6f35_5a35;
		rst_n = 1'b0;
		n_nmi = 1'b1;
		n_irq = 1'b1;
		n_res = 1'b1;
		rdy = 1'b1;
		so = 1'b0;
		core_addr = 16'h0000;
		core_data = 8'h00;
		core_rnw = 1'b1;
		core_fetch = 1'b0;
		pc = 16'h0000;
		p_flags = 8'h04;
		data_in = 8'h00;
		cycle = 0;
		{n_res_seq, n_nmi_seq, n_irq_seq, n_rstall, n_wstall, n_so} = '0;
		repeat (reset_cycles) @(posedge phi0);
		rst_n <= 1'b1;
		while (cycle < run_cycles) begin
			@(posedge phi0);
			drive_inputs();
			cycle++;
		end
		@(posedge phi0);
		// Every kind of entry and stall must have shown up
		if (n_res_seq == 0 || n_nmi_seq == 0 || n_irq_seq == 0 || n_rstall == 0 ||
			n_wstall == 0 || n_so == 0) begin
			fail_run("Stimulus never reached a reset, NMI, IRQ, stall or SO case");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// File: verilog/bus_req_if.sv
`timescale 1ns/1ps

// Sequencer bus cycle towards the output stage
interface bus_req_if;
	import irq_pkg::*;

	// Sequencer owns the bus this cycle
	logic active;
	addr_t addr;
	byte_t data;
	logic rnw;
	// Vector high read completes
	logic vec_done;
	// Captured vector low byte
	byte_t vec_byte;

	modport src (
		output active,
		output addr,
		output data,
		output rnw,
		output vec_done,
		input  vec_byte
	);

	modport dst (
		input  active,
		input  addr,
		input  data,
		input  rnw,
		input  vec_done,
		output vec_byte
	);

endinterface

// File: verilog/bus_result.sv
`timescale 1ns/1ps

module bus_result (
	input  logic           phi0,
	input  logic           rst_n,
	input  irq_pkg::addr_t core_addr,
	input  irq_pkg::byte_t core_data,
	input  logic           core_rnw,
	input  logic           core_fetch,
	input  irq_pkg::byte_t data_in,
	bus_req_if.dst         bus,
	output irq_pkg::addr_t addr,
	output irq_pkg::byte_t data_out,
	output logic           rnw,
	output logic           sync,
	output irq_pkg::addr_t pc_new,
	output logic           pc_load,
	output logic           i_set
);

	import irq_pkg::*;

	// Sequencer read at one of the vector low addresses
	logic vec_lo_hit;

	// Sequencer owns the pins while active
	assign addr     = bus.active ? bus.addr : core_addr;
	assign data_out = bus.active ? bus.data : core_data;
	assign rnw      = bus.active ? bus.rnw : core_rnw;
	// No SYNC during entry, fetch is replaced
	assign sync     = core_fetch & ~bus.active;

	// Dummies come before vec_lo, so a stray match is overwritten
	assign vec_lo_hit = bus.active && bus.rnw &&
		(bus.addr == vec_nmi || bus.addr == vec_res || bus.addr == vec_irq);

	// Vector bytes
	always_ff @(posedge phi0) begin
		// Last stalled cycle leaves the valid byte
		if (vec_lo_hit)
			bus.vec_byte <= data_in;
		// High byte straight off the bus
		if (bus.vec_done)
			pc_new <= {data_in, bus.vec_byte};
	end

	// Strobes one cycle after vec_hi
	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			pc_load <= 1'b0;
			i_set   <= 1'b0;
		end else begin
			pc_load <= bus.vec_done;
			i_set   <= bus.vec_done;
		end
	end

endmodule

// File: verilog/cpu_front.sv
`timescale 1ns/1ps

module cpu_front (
	input  logic           phi0,
	input  logic           rst_n,
	input  logic           n_nmi,
	input  logic           n_irq,
	input  logic           n_res,
	input  logic           rdy,
	input  logic           so,
	input  irq_pkg::addr_t core_addr,
	input  irq_pkg::byte_t core_data,
	input  logic           core_rnw,
	input  logic           core_fetch,
	input  irq_pkg::addr_t pc,
	input  irq_pkg::byte_t p_flags,
	input  irq_pkg::byte_t data_in,
	output irq_pkg::addr_t addr,
	output irq_pkg::byte_t data_out,
	output logic           rnw,
	output logic           sync,
	output irq_pkg::addr_t pc_new,
	output logic           pc_load,
	output logic           i_set,
	output logic           so_set,
	output logic           busy
);

	// Synchronized pin levels
	logic nmi_s;
	logic irq_s;
	logic res_s;
	logic rdy_s;

	int_req_if int_req ();
	bus_req_if bus_req ();

	// Pad registers
	pads_logic u_pads (
		.phi0   (phi0),
		.rst_n  (rst_n),
		.n_nmi  (n_nmi),
		.n_irq  (n_irq),
		.n_res  (n_res),
		.rdy    (rdy),
		.so     (so),
		.nmi_s  (nmi_s),
		.irq_s  (irq_s),
		.res_s  (res_s),
		.rdy_s  (rdy_s),
		.so_set (so_set)
	);

	// Interrupt priority
	int_decode u_decode (
		.phi0    (phi0),
		.rst_n   (rst_n),
		.nmi_s   (nmi_s),
		.irq_s   (irq_s),
		.res_s   (res_s),
		.p_flags (p_flags),
		.req     (int_req)
	);

	// Entry sequence
	int_sequencer u_seq (
		.phi0       (phi0),
		.rst_n      (rst_n),
		.rdy_s      (rdy_s),
		.core_fetch (core_fetch),
		.core_addr  (core_addr),
		.pc         (pc),
		.p_flags    (p_flags),
		.req        (int_req),
		.bus        (bus_req),
		.busy       (busy)
	);

	// Output stage
	bus_result u_result (
		.phi0       (phi0),
		.rst_n      (rst_n),
		.core_addr  (core_addr),
		.core_data  (core_data),
		.core_rnw   (core_rnw),
		.core_fetch (core_fetch),
		.data_in    (data_in),
		.bus        (bus_req),
		.addr       (addr),
		.data_out   (data_out),
		.rnw        (rnw),
		.sync       (sync),
		.pc_new     (pc_new),
		.pc_load    (pc_load),
		.i_set      (i_set)
	);

endmodule

// File: verilog/int_decode.sv
`timescale 1ns/1ps

module int_decode (
	input  logic           phi0,
	input  logic           rst_n,
	input  logic           nmi_s,
	input  logic           irq_s,
	input  logic           res_s,
	input  irq_pkg::byte_t p_flags,
	int_req_if.src         req
);

	import irq_pkg::*;

	// Previous NMI level for edge detection
	logic nmi_prev;
	// Edge seen, not yet serviced
	logic nmi_lat;
	// Reset seen, entry not yet started
	logic res_req;
	int_kind_e kind_c;

	// NMI is edge triggered
	// New edge wins over a clear in the same cycle
	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			nmi_prev <= 1'b0;
			nmi_lat  <= 1'b0;
		end else begin
			nmi_prev <= nmi_s;
			if (nmi_s && !nmi_prev)
				nmi_lat <= 1'b1;
			else if (req.clear_nmi)
				nmi_lat <= 1'b0;
		end
	end

	// Power-up counts as a reset too
	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			res_req <= 1'b1;
		end else if (res_s) begin
			res_req <= 1'b1;
		end else if (req.take && kind_c == res) begin
			res_req <= 1'b0;
		end
	end

	// Priority select
	always_comb begin
		if (res_s) begin
			// Pin still held, nothing runs
			kind_c = none;
		end else if (res_req) begin
			kind_c = res;
		end else if (nmi_lat) begin
			kind_c = nmi;
		end else if (irq_s && !p_flags[i_bit]) begin
			// IRQ is a level, masked by I
			kind_c = irq;
		end else begin
			kind_c = none;
		end
	end

	assign req.kind    = kind_c;
	assign req.pending = (kind_c != none);

endmodule

// File: verilog/int_req_if.sv
`timescale 1ns/1ps

// Pending interrupt from decode to the sequencer
interface int_req_if;
	import irq_pkg::*;

	// Highest priority source right now
	int_kind_e kind;
	// Some source wants service
	logic pending;
	// Sequencer accepts the request, one cycle
	logic take;
	// NMI vector fetched, drop the edge latch
	logic clear_nmi;

	// Decode side
	modport src (
		output kind,
		output pending,
		input  take,
		input  clear_nmi
	);

	// Sequencer side
	modport dst (
		input  kind,
		input  pending,
		output take,
		output clear_nmi
	);

endinterface

// File: verilog/int_sequencer.sv
`timescale 1ns/1ps

module int_sequencer (
	input  logic           phi0,
	input  logic           rst_n,
	input  logic           rdy_s,
	input  logic           core_fetch,
	input  irq_pkg::addr_t core_addr,
	input  irq_pkg::addr_t pc,
	input  irq_pkg::byte_t p_flags,
	int_req_if.dst         req,
	bus_req_if.src         bus,
	output logic           busy
);

	import irq_pkg::*;

	seq_state_e state;
	// Step on the bus this cycle
	seq_state_e step;
	seq_state_e next_step;
	// Source latched at take
	int_kind_e kind_q;
	// Stack pointer
	byte_t sp;
	addr_t vec_addr;
	addr_t addr_c;
	byte_t data_c;
	logic rnw_c;
	logic start;
	logic advance;
	logic push;
	logic vec_done;

	// Normal entry waits for an opcode fetch
	// Reset goes as soon as it is pending
	assign start = (state == idle) && req.pending && (core_fetch || req.kind == res);

	// The accepting cycle is already dummy0
	assign step = start ? dummy0 : state;
	assign busy = (step != idle);

	// Vector from the latched source
	always_comb begin
		case (kind_q)
			res:     vec_addr = vec_res;
			nmi:     vec_addr = vec_nmi;
			default: vec_addr = vec_irq;
		endcase
	end

	// Bus cycle per step
	always_comb begin
		addr_c    = pc;
		data_c    = 8'h00;
		rnw_c     = 1'b1;
		push      = 1'b0;
		next_step = idle;
		case (step)
			dummy0: begin
				// Core's fetch address taken over
				addr_c    = core_addr;
				next_step = dummy1;
			end
			dummy1: begin
				addr_c    = pc;
				next_step = push_pch;
			end
			push_pch: begin
				addr_c    = {stack_page, sp};
				data_c    = pc[15:8];
				// Reset reads instead of writing
				rnw_c     = (kind_q == res);
				push      = 1'b1;
				next_step = push_pcl;
			end
			push_pcl: begin
				addr_c    = {stack_page, sp};
				data_c    = pc[7:0];
				rnw_c     = (kind_q == res);
				push      = 1'b1;
				next_step = push_p;
			end
			push_p: begin
				addr_c    = {stack_page, sp};
				// B flag (bit 4) always clear for hardware entry
				data_c    = p_flags & 8'hef;
				rnw_c     = (kind_q == res);
				push      = 1'b1;
				next_step = vec_lo;
			end
			vec_lo: begin
				addr_c    = vec_addr;
				next_step = vec_hi;
			end
			vec_hi: begin
				addr_c    = vec_addr | 16'h0001;
				next_step = idle;
			end
			default: begin
				next_step = idle;
			end
		endcase
	end

	// Reads hold on RDY low, writes always go
	assign advance  = ~rnw_c | rdy_s;
	assign vec_done = (step == vec_hi) && advance;

	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			state  <= idle;
			kind_q <= none;
			sp     <= 8'h00;
		end else begin
			if (start)
				kind_q <= req.kind;
			// Stalled step repeats with the same address
			state <= advance ? next_step : step;
			// Post-decrement once per completed push
			if (advance && push)
				sp <= sp - 8'd1;
		end
	end

	assign req.take      = start;
	assign req.clear_nmi = vec_done && (kind_q == nmi);

	assign bus.active   = busy;
	assign bus.addr     = addr_c;
	assign bus.data     = data_c;
	assign bus.rnw      = rnw_c;
	assign bus.vec_done = vec_done;

endmodule

// File: verilog/irq_pkg.sv
package irq_pkg;

	// Bus address and data widths
	typedef logic [15:0] addr_t;
	// Data byte, also used for the P register
	typedef logic [7:0] byte_t;

	// Interrupt source, in no particular order
	typedef enum logic [1:0] {
		none,
		res,
		nmi,
		irq
	} int_kind_e;

	// Entry sequence steps, one bus cycle each
	typedef enum logic [2:0] {
		idle,
		dummy0,
		dummy1,
		push_pch,
		push_pcl,
		push_p,
		vec_lo,
		vec_hi
	} seq_state_e;

	// Vector low byte addresses
	localparam addr_t vec_nmi = 16'hfffa;
	localparam addr_t vec_res = 16'hfffc;
	localparam addr_t vec_irq = 16'hfffe;

	// Stack lives in page one
	localparam byte_t stack_page = 8'h01;

	// Interrupt disable flag position in P
	localparam int i_bit = 2;

endpackage

// File: verilog/pads_logic.sv
`timescale 1ns/1ps

module pads_logic (
	input  logic phi0,
	input  logic rst_n,
	input  logic n_nmi,
	input  logic n_irq,
	input  logic n_res,
	input  logic rdy,
	input  logic so,
	output logic nmi_s,
	output logic irq_s,
	output logic res_s,
	output logic rdy_s,
	output logic so_set
);

	// SO delay chain
	logic so_q;
	logic so_d1;
	logic so_d2;

	// One register per pin, pad delay of one cycle
	// Active-low pins come out active high
	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			nmi_s <= 1'b0;
			irq_s <= 1'b0;
			// Reset pin reads as held while rst_n is low
			res_s <= 1'b1;
			rdy_s <= 1'b1;
		end else begin
			nmi_s <= ~n_nmi;
			irq_s <= ~n_irq;
			res_s <= ~n_res;
			rdy_s <= rdy;
		end
	end

	// SO sampled, then delayed twice
	// Edge taken on the delayed pair so the pulse lands two cycles late
	always_ff @(posedge phi0 or negedge rst_n) begin
		if (!rst_n) begin
			so_q   <= 1'b0;
			so_d1  <= 1'b0;
			so_d2  <= 1'b0;
			so_set <= 1'b0;
		end else begin
			so_q  <= so;
			so_d1 <= so_q;
			so_d2 <= so_d1;
			// High then low, single cycle pulse
			so_set <= so_d2 & ~so_d1;
		end
	end

endmodule

// File: vlog.f
+incdir+sim
verilog/irq_pkg.sv
verilog/int_req_if.sv
verilog/bus_req_if.sv
verilog/pads_logic.sv
verilog/int_decode.sv
verilog/int_sequencer.sv
verilog/bus_result.sv
verilog/cpu_front.sv
sim/tb_cpu_front.sv
